//--- include/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// Total entries over both banks.
`define ROB_SIZE 16

// Result buses broadcasting per cycle.
`define CDB_SIZE 2

// Operand read ports.
`define ROB_RPORTS 4

`endif

//--- hw/rob_pkg.sv
`default_nettype none

`include "rob_config.svh"

package rob_pkg;

	localparam int TAG_WIDTH  = $clog2(`ROB_SIZE);
	localparam int SLOT_WIDTH = TAG_WIDTH - 1;

	typedef logic [31:0] uint32_t;

	// The lowest tag bit picks the bank, the rest is the slot in it.
	typedef struct packed {
		logic [SLOT_WIDTH-1:0] slot;
		logic                  bank;
	} rob_tag_split_t;

	typedef union packed {
		logic [TAG_WIDTH-1:0] flat;
		rob_tag_split_t       split;
	} rob_tag_t;

	typedef struct packed {
		logic       busy;
		logic [4:0] rd;
		uint32_t    value;
	} rob_entry_t;

	typedef struct packed {
		logic     valid;
		rob_tag_t reorder;
		uint32_t  value;
	} cdb_elem_t;

	typedef cdb_elem_t [`CDB_SIZE-1:0] cdb_packet_t;

endpackage

`default_nettype wire

//--- hw/rob_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_channel #(
	parameter int ID       = 0,
	parameter int ID_WIDTH = 1,
	parameter int DEPTH    = 8
) (
	input  wire logic                                         clk,
	input  wire logic                                         rst,
	input  wire logic                                         flush,

	input  wire logic                                         push,
	input  wire logic                                         pop,
	input  wire rob_pkg::rob_entry_t                          data_i,
	output rob_pkg::rob_entry_t                               data_o,
	output logic [$clog2(DEPTH)-1:0]                          write_pointer,

	input  wire logic [`ROB_RPORTS-1:0][$clog2(DEPTH)-1:0]    rob_raddr,
	output logic [`ROB_RPORTS-1:0]                            rob_rdata_valid,
	output rob_pkg::uint32_t [`ROB_RPORTS-1:0]                rob_rdata,

	input  wire rob_pkg::cdb_packet_t                         cdb
);

	import rob_pkg::*;

	localparam int ADDR_WIDTH = $clog2(DEPTH);

	logic [ADDR_WIDTH-1:0] rd_ptr_q;
	logic [ADDR_WIDTH-1:0] rd_ptr_n;
	logic [ADDR_WIDTH-1:0] wr_ptr_q;
	logic [ADDR_WIDTH-1:0] wr_ptr_n;
	rob_entry_t [DEPTH-1:0] mem_q;
	rob_entry_t [DEPTH-1:0] mem_n;

	logic [`CDB_SIZE-1:0]                 cdb_hit;
	logic [`CDB_SIZE-1:0][ADDR_WIDTH-1:0] cdb_slot;

	function automatic logic [ADDR_WIDTH-1:0] next_ptr(input logic [ADDR_WIDTH-1:0] ptr);
		if (ptr == ADDR_WIDTH'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign write_pointer = wr_ptr_q;
	assign data_o        = mem_q[rd_ptr_q];

	// Only results tagged for this bank land here.
	always_comb begin
		for (int i = 0; i < `CDB_SIZE; i++) begin
			cdb_hit[i]  = cdb[i].valid
				&& cdb[i].reorder.flat[ID_WIDTH-1:0] == ID[ID_WIDTH-1:0];
			cdb_slot[i] = cdb[i].reorder.flat[TAG_WIDTH-1:ID_WIDTH];
		end
	end

	always_comb begin
		mem_n = mem_q;
		if (push)
			mem_n[wr_ptr_q] = data_i;
		// Later lanes win on a shared tag.
		for (int i = 0; i < `CDB_SIZE; i++) begin
			if (cdb_hit[i]) begin
				mem_n[cdb_slot[i]].busy  = 1'b0;
				mem_n[cdb_slot[i]].value = cdb[i].value;
			end
		end
	end

	// Reads see this cycle's broadcasts.
	always_comb begin
		for (int p = 0; p < `ROB_RPORTS; p++) begin
			rob_rdata[p]       = mem_n[rob_raddr[p]].value;
			rob_rdata_valid[p] = !mem_n[rob_raddr[p]].busy;
		end
	end

	always_comb begin
		rd_ptr_n = pop ? next_ptr(rd_ptr_q) : rd_ptr_q;
		wr_ptr_n = push ? next_ptr(wr_ptr_q) : wr_ptr_q;
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
		end else begin
			rd_ptr_q <= rd_ptr_n;
			wr_ptr_q <= wr_ptr_n;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			mem_q <= '0;
		else
			mem_q <= mem_n;
	end

	// The commit unit pops this bank only once its head has a result.
	a_pop_done: assert property (@(posedge clk) disable iff (rst)
		pop |-> !mem_q[rd_ptr_q].busy);

endmodule

`default_nettype wire

//--- hw/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_alloc (
	input  wire logic                            clk,
	input  wire logic                            rst,
	input  wire logic                            flush,
	input  wire logic                            dispatch,
	input  wire logic                            commit,
	input  wire logic [rob_pkg::SLOT_WIDTH-1:0]  write_pointer_even,
	input  wire logic [rob_pkg::SLOT_WIDTH-1:0]  write_pointer_odd,
	output logic                                 alloc_bank,
	output rob_pkg::rob_tag_t                    dispatch_tag,
	output logic                                 full,
	output logic                                 empty
);

	import rob_pkg::*;

	// Program order alternates banks, so the bank bit is the tag LSB.
	logic               bank_q;
	logic [TAG_WIDTH:0] count_q;

	assign alloc_bank = bank_q;
	assign full       = count_q == (TAG_WIDTH + 1)'(`ROB_SIZE);
	assign empty      = count_q == '0;

	always_comb begin
		dispatch_tag.split.bank = bank_q;
		dispatch_tag.split.slot = bank_q ? write_pointer_odd : write_pointer_even;
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			bank_q  <= 1'b0;
			count_q <= '0;
		end else begin
			if (dispatch)
				bank_q <= !bank_q;
			if (dispatch && !commit)
				count_q <= count_q + 1'b1;
			else if (commit && !dispatch)
				count_q <= count_q - 1'b1;
		end
	end

	// Dispatch is not gated here.
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		dispatch |-> !full);

endmodule

`default_nettype wire

//--- hw/rob_commit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_commit (
	input  wire logic                                             clk,
	input  wire logic                                             rst,
	input  wire logic                                             flush,
	input  wire logic                                             empty,
	input  wire rob_pkg::rob_entry_t                              head_even,
	input  wire rob_pkg::rob_entry_t                              head_odd,

	input  wire rob_pkg::rob_tag_t [`ROB_RPORTS-1:0]              rob_raddr,
	input  wire rob_pkg::uint32_t [`ROB_RPORTS-1:0]               rdata_even,
	input  wire logic [`ROB_RPORTS-1:0]                           rdata_valid_even,
	input  wire rob_pkg::uint32_t [`ROB_RPORTS-1:0]               rdata_odd,
	input  wire logic [`ROB_RPORTS-1:0]                           rdata_valid_odd,

	output logic                                                  pop_even,
	output logic                                                  pop_odd,
	output logic                                                  commit,
	output logic [4:0]                                            commit_rd,
	output rob_pkg::uint32_t                                      commit_value,
	output rob_pkg::rob_tag_t                                     commit_tag,

	output logic [`ROB_RPORTS-1:0][rob_pkg::SLOT_WIDTH-1:0]       slot_raddr,
	output rob_pkg::uint32_t [`ROB_RPORTS-1:0]                    rob_rdata,
	output logic [`ROB_RPORTS-1:0]                                rob_rdata_valid
);

	import rob_pkg::*;

	// Tag of the oldest entry; its bank bit is the bank pointer.
	rob_tag_t   head_q;
	rob_entry_t head;

	always_comb begin
		head = head_q.split.bank ? head_odd : head_even;

		commit       = !empty && !head.busy;
		commit_rd    = head.rd;
		commit_value = head.value;
		commit_tag   = head_q;

		pop_even = commit && !head_q.split.bank;
		pop_odd  = commit && head_q.split.bank;
	end

	always_ff @(posedge clk) begin
		if (rst || flush)
			head_q <= '0;
		else if (commit)
			head_q.flat <= head_q.flat + 1'b1;
	end

	// Both banks share the slot index, the bank bit picks the answer.
	always_comb begin
		for (int p = 0; p < `ROB_RPORTS; p++) begin
			slot_raddr[p] = rob_raddr[p].split.slot;
			if (rob_raddr[p].split.bank) begin
				rob_rdata[p]       = rdata_odd[p];
				rob_rdata_valid[p] = rdata_valid_odd[p];
			end else begin
				rob_rdata[p]       = rdata_even[p];
				rob_rdata_valid[p] = rdata_valid_even[p];
			end
		end
	end

	// The allocator count drops to zero on a flush, so nothing retires next cycle.
	a_no_commit_empty: assert property (@(posedge clk) disable iff (rst)
		flush |=> !commit);

endmodule

`default_nettype wire

//--- hw/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_top (
	input  wire logic                                  clk,
	input  wire logic                                  rst,
	input  wire logic                                  flush,

	input  wire logic                                  dispatch,
	input  wire logic [4:0]                            dispatch_rd,
	output rob_pkg::rob_tag_t                          dispatch_tag,
	output logic                                       full,

	input  wire rob_pkg::cdb_packet_t                  cdb,

	output logic                                       commit,
	output logic [4:0]                                 commit_rd,
	output rob_pkg::uint32_t                           commit_value,
	output rob_pkg::rob_tag_t                          commit_tag,

	input  wire rob_pkg::rob_tag_t [`ROB_RPORTS-1:0]   rob_raddr,
	output rob_pkg::uint32_t [`ROB_RPORTS-1:0]         rob_rdata,
	output logic [`ROB_RPORTS-1:0]                     rob_rdata_valid
);

	import rob_pkg::*;

	localparam int BANK_DEPTH = `ROB_SIZE / 2;

	logic alloc_bank;
	logic empty;
	logic push_even;
	logic push_odd;
	logic pop_even;
	logic pop_odd;

	logic [SLOT_WIDTH-1:0] wp_even;
	logic [SLOT_WIDTH-1:0] wp_odd;

	rob_entry_t new_entry;
	rob_entry_t head_even;
	rob_entry_t head_odd;

	logic [`ROB_RPORTS-1:0][SLOT_WIDTH-1:0] slot_raddr;
	uint32_t [`ROB_RPORTS-1:0]              rdata_even;
	uint32_t [`ROB_RPORTS-1:0]              rdata_odd;
	logic [`ROB_RPORTS-1:0]                 rdata_valid_even;
	logic [`ROB_RPORTS-1:0]                 rdata_valid_odd;

	// New entries wait for their result.
	assign new_entry = '{busy: 1'b1, rd: dispatch_rd, value: '0};
	assign push_even = dispatch && !alloc_bank;
	assign push_odd  = dispatch && alloc_bank;

	rob_alloc u_alloc (
		.clk                (clk),
		.rst                (rst),
		.flush              (flush),
		.dispatch           (dispatch),
		.commit             (commit),
		.write_pointer_even (wp_even),
		.write_pointer_odd  (wp_odd),
		.alloc_bank         (alloc_bank),
		.dispatch_tag       (dispatch_tag),
		.full               (full),
		.empty              (empty)
	);

	rob_channel #(.ID(0), .ID_WIDTH(1), .DEPTH(BANK_DEPTH)) u_bank_even (
		.clk             (clk),
		.rst             (rst),
		.flush           (flush),
		.push            (push_even),
		.pop             (pop_even),
		.data_i          (new_entry),
		.data_o          (head_even),
		.write_pointer   (wp_even),
		.rob_raddr       (slot_raddr),
		.rob_rdata_valid (rdata_valid_even),
		.rob_rdata       (rdata_even),
		.cdb             (cdb)
	);

	rob_channel #(.ID(1), .ID_WIDTH(1), .DEPTH(BANK_DEPTH)) u_bank_odd (
		.clk             (clk),
		.rst             (rst),
		.flush           (flush),
		.push            (push_odd),
		.pop             (pop_odd),
		.data_i          (new_entry),
		.data_o          (head_odd),
		.write_pointer   (wp_odd),
		.rob_raddr       (slot_raddr),
		.rob_rdata_valid (rdata_valid_odd),
		.rob_rdata       (rdata_odd),
		.cdb             (cdb)
	);

	rob_commit u_commit (
		.clk              (clk),
		.rst              (rst),
		.flush            (flush),
		.empty            (empty),
		.head_even        (head_even),
		.head_odd         (head_odd),
		.rob_raddr        (rob_raddr),
		.rdata_even       (rdata_even),
		.rdata_valid_even (rdata_valid_even),
		.rdata_odd        (rdata_odd),
		.rdata_valid_odd  (rdata_valid_odd),
		.pop_even         (pop_even),
		.pop_odd          (pop_odd),
		.commit           (commit),
		.commit_rd        (commit_rd),
		.commit_value     (commit_value),
		.commit_tag       (commit_tag),
		.slot_raddr       (slot_raddr),
		.rob_rdata        (rob_rdata),
		.rob_rdata_valid  (rob_rdata_valid)
	);

endmodule

`default_nettype wire

//--- tests/rob_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_checker (
	input  wire logic                                  clk,
	input  wire logic                                  rst,
	input  wire logic                                  flush,
	input  wire logic                                  dispatch,
	input  wire logic [4:0]                            dispatch_rd,
	input  wire rob_pkg::rob_tag_t                     dispatch_tag,
	input  wire logic                                  full,
	input  wire rob_pkg::cdb_packet_t                  cdb,
	input  wire logic                                  commit,
	input  wire logic [4:0]                            commit_rd,
	input  wire rob_pkg::uint32_t                      commit_value,
	input  wire rob_pkg::rob_tag_t                     commit_tag,
	input  wire rob_pkg::rob_tag_t [`ROB_RPORTS-1:0]   rob_raddr,
	input  wire rob_pkg::uint32_t [`ROB_RPORTS-1:0]    rob_rdata,
	input  wire logic [`ROB_RPORTS-1:0]                rob_rdata_valid,
	output int                                         errors,
	output int                                         checks,
	output int                                         outstanding
);

	import rob_pkg::*;

	typedef struct packed {
		logic [TAG_WIDTH-1:0] tag;
		logic [4:0]           rd;
		logic                 busy;
		uint32_t              value;
	} model_entry_t;

	// Oldest entry sits at the front.
	model_entry_t         model_q[$];
	logic [TAG_WIDTH-1:0] next_tag;
	int                   error_count = 0;
	int                   check_count = 0;
	int                   held = 0;

	assign errors      = error_count;
	assign checks      = check_count;
	assign outstanding = held;

	task automatic compare_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic int find_tag(input logic [TAG_WIDTH-1:0] tag);
		for (int i = 0; i < model_q.size(); i++) begin
			if (model_q[i].tag == tag)
				return i;
		end
		return -1;
	endfunction

	always @(posedge clk) begin
		int      idx;
		logic    exp_commit;
		logic    busy_n;
		uint32_t value_n;
		if (rst) begin
			model_q.delete();
			next_tag = '0;
		end else begin
			compare_value("full", 32'(full), 32'(model_q.size() == `ROB_SIZE));
			exp_commit = model_q.size() > 0 && !model_q[0].busy;
			compare_value("commit", 32'(commit), 32'(exp_commit));
			if (exp_commit && commit) begin
				compare_value("commit_tag", 32'(commit_tag.flat), 32'(model_q[0].tag));
				compare_value("commit_rd", 32'(commit_rd), 32'(model_q[0].rd));
				compare_value("commit_value", commit_value, model_q[0].value);
			end
			if (dispatch)
				compare_value("dispatch_tag", 32'(dispatch_tag.flat), 32'(next_tag));

			// Only held tags have a defined read result.
			for (int p = 0; p < `ROB_RPORTS; p++) begin
				idx = find_tag(rob_raddr[p].flat);
				if (idx >= 0) begin
					busy_n  = model_q[idx].busy;
					value_n = model_q[idx].value;
					for (int l = 0; l < `CDB_SIZE; l++) begin
						if (cdb[l].valid && cdb[l].reorder.flat == rob_raddr[p].flat) begin
							busy_n  = 1'b0;
							value_n = cdb[l].value;
						end
					end
					compare_value($sformatf("rob_rdata_valid[%0d]", p),
						32'(rob_rdata_valid[p]), 32'(!busy_n));
					if (!busy_n)
						compare_value($sformatf("rob_rdata[%0d]", p), rob_rdata[p], value_n);
				end
			end

			for (int l = 0; l < `CDB_SIZE; l++) begin
				idx = cdb[l].valid ? find_tag(cdb[l].reorder.flat) : -1;
				if (idx >= 0) begin
					model_q[idx].busy  = 1'b0;
					model_q[idx].value = cdb[l].value;
				end
			end
			if (exp_commit)
				void'(model_q.pop_front());
			if (dispatch) begin
				model_q.push_back('{tag: next_tag, rd: dispatch_rd, busy: 1'b1, value: '0});
				next_tag = next_tag + 1'b1;
			end
			if (flush) begin
				model_q.delete();
				next_tag = '0;
			end
		end

		// Entries the DUT has taken in and not yet retired.
		if (rst || flush)
			held = 0;
		else
			held = held + int'(dispatch) - int'(commit);
	end

endmodule

`default_nettype wire

//--- tests/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_tb;

	import rob_pkg::*;

	localparam int NUM_ROWS    = 38;
	localparam int DRAIN_LIMIT = 40;

	typedef struct packed {
		logic       dispatch;
		logic [4:0] rd;
		logic       v0;
		logic [3:0] t0;
		logic       v1;
		logic [3:0] t1;
		logic       flush;
		logic [3:0] ra0;
		logic [3:0] ra1;
		logic [3:0] ra2;
		logic [3:0] ra3;
	} stim_row_t;

	logic                           clk;
	logic                           rst;
	logic                           flush;
	logic                           dispatch;
	logic [4:0]                     dispatch_rd;
	cdb_packet_t                    cdb;
	rob_tag_t [`ROB_RPORTS-1:0]     rob_raddr;
	rob_tag_t                       dispatch_tag;
	logic                           full;
	logic                           commit;
	logic [4:0]                     commit_rd;
	uint32_t                        commit_value;
	rob_tag_t                       commit_tag;
	uint32_t [`ROB_RPORTS-1:0]      rob_rdata;
	logic [`ROB_RPORTS-1:0]         rob_rdata_valid;

	int          errors;
	int          checks;
	int          outstanding;
	logic        hung;
	logic [31:0] lfsr_state;

	// Columns: dispatch, rd, lane 0 valid and tag, lane 1 valid and tag, flush, read tags.
	stim_row_t stim [NUM_ROWS] = '{
		'{1'b1, 5'd1,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b1, 5'd2,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b1, 5'd3,  1'b1, 4'd1,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b1, 5'd4,  1'b1, 4'd2,  1'b1, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b1, 4'd3,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b0, 5'd0,  1'b1, 4'd2,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd2,  4'd3,  4'd0,  4'd1},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd2,  4'd3,  4'd0,  4'd1},
		'{1'b1, 5'd5,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd4,  4'd5,  4'd6,  4'd7},
		'{1'b1, 5'd6,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd4,  4'd5,  4'd6,  4'd7},
		'{1'b1, 5'd7,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd4,  4'd5,  4'd6,  4'd7},
		'{1'b1, 5'd8,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd4,  4'd5,  4'd6,  4'd7},
		'{1'b1, 5'd9,  1'b1, 4'd5,  1'b1, 4'd7,  1'b0, 4'd4,  4'd5,  4'd6,  4'd7},
		'{1'b1, 5'd10, 1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd5,  4'd6,  4'd7,  4'd8},
		'{1'b1, 5'd11, 1'b1, 4'd6,  1'b1, 4'd6,  1'b0, 4'd5,  4'd6,  4'd8,  4'd9},
		'{1'b1, 5'd12, 1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd6,  4'd8,  4'd9,  4'd10},
		'{1'b1, 5'd13, 1'b1, 4'd9,  1'b1, 4'd8,  1'b0, 4'd8,  4'd9,  4'd10, 4'd11},
		'{1'b1, 5'd14, 1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd9,  4'd10, 4'd11, 4'd12},
		'{1'b1, 5'd15, 1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd10, 4'd11, 4'd12, 4'd13},
		'{1'b1, 5'd16, 1'b0, 4'd0,  1'b1, 4'd11, 1'b0, 4'd11, 4'd12, 4'd13, 4'd14},
		'{1'b1, 5'd17, 1'b1, 4'd10, 1'b0, 4'd0,  1'b0, 4'd12, 4'd13, 4'd14, 4'd15},
		'{1'b1, 5'd18, 1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd13, 4'd14, 4'd15, 4'd0},
		'{1'b1, 5'd19, 1'b1, 4'd13, 1'b1, 4'd12, 1'b0, 4'd12, 4'd13, 4'd14, 4'd0},
		'{1'b1, 5'd20, 1'b1, 4'd0,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b0, 5'd0,  1'b1, 4'd4,  1'b1, 4'd15, 1'b0, 4'd4,  4'd15, 4'd14, 4'd1},
		'{1'b0, 5'd0,  1'b1, 4'd14, 1'b1, 4'd1,  1'b0, 4'd4,  4'd5,  4'd14, 4'd1},
		'{1'b1, 5'd21, 1'b1, 4'd2,  1'b1, 4'd3,  1'b0, 4'd5,  4'd6,  4'd2,  4'd3},
		'{1'b1, 5'd22, 1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd4,  4'd6,  4'd7,  4'd8},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd4,  4'd5,  4'd7,  4'd8},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd8,  4'd9,  4'd10, 4'd11},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b0, 4'd0,  1'b1, 4'd9,  4'd10, 4'd11, 4'd12},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b1, 5'd23, 1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b1, 5'd24, 1'b1, 4'd0,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b0, 5'd0,  1'b1, 4'd1,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3},
		'{1'b0, 5'd0,  1'b0, 4'd0,  1'b0, 4'd0,  1'b0, 4'd0,  4'd1,  4'd2,  4'd3}
	};

	function automatic logic next_lfsr_bit();
		logic out;
		out        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return out;
	endfunction

	function automatic uint32_t random_word();
		uint32_t word;
		word = '0;
		for (int i = 0; i < 32; i++)
			word = {word[30:0], next_lfsr_bit()};
		return word;
	endfunction

	task automatic drive_idle();
		flush       = 1'b0;
		dispatch    = 1'b0;
		dispatch_rd = '0;
		cdb         = '0;
		rob_raddr   = '0;
	endtask

	task automatic apply_row(input stim_row_t row);
		dispatch            = row.dispatch;
		dispatch_rd         = row.rd;
		flush               = row.flush;
		cdb[0].valid        = row.v0;
		cdb[0].reorder.flat = row.t0;
		cdb[0].value        = row.v0 ? random_word() : '0;
		cdb[1].valid        = row.v1;
		cdb[1].reorder.flat = row.t1;
		cdb[1].value        = row.v1 ? random_word() : '0;
		rob_raddr[0].flat   = row.ra0;
		rob_raddr[1].flat   = row.ra1;
		rob_raddr[2].flat   = row.ra2;
		rob_raddr[3].flat   = row.ra3;
	endtask

	task automatic reset_dut();
		rst = 1'b1;
		drive_idle();
		repeat (8) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		@(negedge clk);
		drive_idle();
		while (outstanding != 0 && cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (outstanding != 0) begin
			$display("Timeout: %0d ROB entries never committed", outstanding);
			hung = 1'b1;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	rob_top UUT (
		.clk             (clk),
		.rst             (rst),
		.flush           (flush),
		.dispatch        (dispatch),
		.dispatch_rd     (dispatch_rd),
		.dispatch_tag    (dispatch_tag),
		.full            (full),
		.cdb             (cdb),
		.commit          (commit),
		.commit_rd       (commit_rd),
		.commit_value    (commit_value),
		.commit_tag      (commit_tag),
		.rob_raddr       (rob_raddr),
		.rob_rdata       (rob_rdata),
		.rob_rdata_valid (rob_rdata_valid)
	);

	rob_checker u_checker (
		.clk             (clk),
		.rst             (rst),
		.flush           (flush),
		.dispatch        (dispatch),
		.dispatch_rd     (dispatch_rd),
		.dispatch_tag    (dispatch_tag),
		.full            (full),
		.cdb             (cdb),
		.commit          (commit),
		.commit_rd       (commit_rd),
		.commit_value    (commit_value),
		.commit_tag      (commit_tag),
		.rob_raddr       (rob_raddr),
		.rob_rdata       (rob_rdata),
		.rob_rdata_valid (rob_rdata_valid),
		.errors          (errors),
		.checks          (checks),
		.outstanding     (outstanding)
	);

	// Two passes, so tags must restart at 0 after the second reset.
	initial begin
		hung       = 1'b0;
		lfsr_state = 32'ha542;
		for (int pass = 0; pass < 2; pass++) begin
			reset_dut();
			for (int r = 0; r < NUM_ROWS; r++) begin
				@(negedge clk);
				apply_row(stim[r]);
			end
			wait_drain();
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && !hung) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hw/rob_pkg.sv
hw/rob_channel.sv
hw/rob_alloc.sv
hw/rob_commit.sv
hw/rob_top.sv
tests/rob_checker.sv
tests/rob_tb.sv

//--- Makefile
SOURCES := $(filter-out +%,$(shell cat flist.f)) include/rob_config.svh

.PHONY: all run clean

all: run

obj_dir/Vrob_tb: flist.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ps --top-module rob_tb -f flist.f

run: obj_dir/Vrob_tb
	@out="$$(./obj_dir/Vrob_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
